// File: data_store.sv
`include "dso_config.svh"

module data_store (
  input  logic                    ad_clk,
  input  logic                    rstn,
  input  logic [`DSO_DATA_W-1:0]  sample_data,
  input  logic                    deci_valid,
  input  logic                    wave_run,
  input  logic                    trig_edge,
  input  logic [`DSO_DATA_W-1:0]  trig_level,
  input  logic [`DSO_SHIFT_W-1:0] h_shift,
  input  logic                    sweep_done,
  input  logic [`DSO_ADDR_W-1:0]  col_addr,
  output logic [`DSO_DATA_W-1:0]  col_data,
  output logic                    frame_ready,
  output dso_pkg::capture_phase_e capture_phase
);
  import dso_pkg::*;

  localparam int SUM_W = `DSO_ADDR_W + 2;
  localparam logic [`DSO_ADDR_W-1:0] H_LEN  = `DSO_ADDR_W'(`DSO_HORIZONTAL);
  localparam logic [`DSO_ADDR_W-1:0] H_LAST = `DSO_ADDR_W'(`DSO_HORIZONTAL - 1);
  localparam logic [`DSO_ADDR_W-1:0] H_HALF = `DSO_ADDR_W'(`DSO_HORIZONTAL / 2);
  localparam logic [SUM_W-1:0]       SUM_H  = SUM_W'(`DSO_HORIZONTAL);
  localparam logic [SUM_W-1:0]       SUM_2H = SUM_W'(2 * `DSO_HORIZONTAL);

  logic [`DSO_ADDR_W-1:0]  wr_addr;
  logic [`DSO_ADDR_W-1:0]  cnt;           // strobes stored in this frame
  logic [`DSO_ADDR_W-1:0]  trig_addr;
  logic [`DSO_ADDR_W-1:0]  trig_base;
  logic [`DSO_ADDR_W-1:0]  rd_addr;
  logic [`DSO_DATA_W-1:0]  hist0;         // previous sample
  logic [`DSO_DATA_W-1:0]  hist1;
  logic [`DSO_DATA_W-1:0]  hist2;         // oldest
  logic [`DSO_DATA_W-1:0]  ram_rd_data;
  logic [`DSO_SHIFT_W-2:0] shift_mag;
  logic [SUM_W-1:0]        col_shifted;
  logic [SUM_W-1:0]        map_sum;
  logic                    shift_right;
  logic                    wr_en;
  logic                    trig_hit;
  logic                    off_screen;
  logic                    out_range;

  // ********************
  // write side
  // ********************
  assign wr_en = deci_valid && wave_run && (cnt < H_LEN);

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wr_addr <= '0;
    end else if (deci_valid) begin
      wr_addr <= (wr_addr == H_LAST) ? '0 : wr_addr + 1'b1;
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      hist0 <= '0;
      hist1 <= '0;
      hist2 <= '0;
    end else if (deci_valid) begin
      hist0 <= sample_data;
      hist1 <= hist0;
      hist2 <= hist1;
    end
  end

  // four-sample crossing, current sample is the newest
  assign trig_hit = trig_edge ?
    ((hist2 < trig_level) && (hist1 < trig_level) &&
     (hist0 >= trig_level) && (sample_data > trig_level)) :
    ((hist2 > trig_level) && (hist1 > trig_level) &&
     (hist0 <= trig_level) && (sample_data < trig_level));

  assign trig_base = (wr_addr >= H_LEN - 2'd2) ? wr_addr + 2'd2 - H_LEN : wr_addr + 2'd2;

  // ********************
  // capture phases
  // ********************
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      capture_phase <= PRE_FILL;
      cnt           <= '0;
      trig_addr     <= '0;
    end else begin
      case (capture_phase)
        PRE_FILL: if (wr_en) begin
          cnt <= cnt + 1'b1;
          if (cnt == H_HALF - 1'b1) capture_phase <= ARMED;  // half screen stored
        end
        ARMED: if (wr_en && trig_hit) begin
          capture_phase <= POST_FILL;
          trig_addr     <= trig_base;
        end
        POST_FILL: if (wr_en) begin
          cnt <= cnt + 1'b1;                         // runs on to H_LEN
          if (cnt == H_LAST) capture_phase <= FULL;
        end
        FULL: if (sweep_done && wave_run) begin
          capture_phase <= PRE_FILL;                 // re-arm for next frame
          cnt           <= '0;
        end
        default: capture_phase <= PRE_FILL;
      endcase
    end
  end

  assign frame_ready = (capture_phase == FULL);

  // ********************
  // column to ram address
  // ********************
  assign shift_right = h_shift[`DSO_SHIFT_W-1];
  assign shift_mag   = h_shift[`DSO_SHIFT_W-2:0];
  assign col_shifted = shift_right ? SUM_W'(col_addr) - SUM_W'(shift_mag) :
                                     SUM_W'(col_addr) + SUM_W'(shift_mag);
  assign off_screen  = shift_right ? (col_addr < shift_mag) : (col_shifted > SUM_W'(H_LAST));

  // trig_addr - H/2 is the same as trig_addr + H/2 modulo H
  assign map_sum = col_shifted + SUM_W'(trig_addr) + SUM_W'(H_HALF);

  always_comb begin
    if (map_sum >= SUM_2H) rd_addr = `DSO_ADDR_W'(map_sum - SUM_2H);
    else if (map_sum >= SUM_H) rd_addr = `DSO_ADDR_W'(map_sum - SUM_H);
    else rd_addr = `DSO_ADDR_W'(map_sum);
  end

  // registered with the ram read so flag and data line up
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) out_range <= 1'b0;
    else out_range <= off_screen;
  end

  assign col_data = out_range ? '1 : ram_rd_data;

  dso_ram_2port u_dso_ram_2port (
    .ad_clk  (ad_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (sample_data),
    .rd_addr (rd_addr),
    .rd_data (ram_rd_data)
  );

endmodule

// File: dso_apb_regs.sv
`include "dso_config.svh"

module dso_apb_regs (
  input  logic                         ad_clk,
  input  logic                         rstn,
  input  logic                         psel,
  input  logic                         penable,
  input  logic                         pwrite,
  input  logic [7:0]                   paddr,
  input  logic [31:0]                  pwdata,
  input  dso_pkg::capture_phase_e      capture_phase,
  input  logic                         frame_done,
  output logic [31:0]                  prdata,
  output logic                         pready,
  output logic                         pslverr,
  output logic                         wave_run,
  output logic                         trig_edge,
  output logic [`DSO_DATA_W-1:0]       trig_level,
  output logic [`DSO_SHIFT_W-1:0]      h_shift,
  output logic [`DSO_DECI_W-1:0]       deci_ratio
);
  import dso_pkg::*;

  dso_reg_e   reg_sel;
  logic       access;
  logic       wr_ok;
  logic [7:0] frame_cnt;

  always_comb begin
    case (paddr)
      `DSO_REG_CTRL:   reg_sel = REG_CTRL;
      `DSO_REG_LEVEL:  reg_sel = REG_LEVEL;
      `DSO_REG_SHIFT:  reg_sel = REG_SHIFT;
      `DSO_REG_DECI:   reg_sel = REG_DECI;
      `DSO_REG_STATUS: reg_sel = REG_STATUS;
      default:         reg_sel = REG_NONE;
    endcase
  end

  assign access  = psel && penable;
  assign pready  = 1'b1;                             // zero wait states
  assign pslverr = access && ((reg_sel == REG_NONE) ||
                              (pwrite && (reg_sel == REG_STATUS)));
  assign wr_ok   = access && pwrite && !pslverr;

  // ********************
  // control registers
  // ********************
  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      wave_run   <= 1'b0;                            // capture stopped
      trig_edge  <= 1'b1;                            // rising
      trig_level <= 8'd128;                          // mid scale
      h_shift    <= '0;
      deci_ratio <= '0;
    end else if (wr_ok) begin
      case (reg_sel)
        REG_CTRL: begin
          wave_run  <= pwdata[0];
          trig_edge <= pwdata[1];
        end
        REG_LEVEL: trig_level <= pwdata[`DSO_DATA_W-1:0];
        REG_SHIFT: h_shift    <= pwdata[`DSO_SHIFT_W-1:0];
        REG_DECI:  deci_ratio <= pwdata[`DSO_DECI_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      frame_cnt <= '0;
    end else if (frame_done) begin
      frame_cnt <= frame_cnt + 1'b1;                 // one per finished sweep
    end
  end

  // readback mux
  always_comb begin
    prdata = '0;
    case (reg_sel)
      REG_CTRL:   prdata[1:0] = {trig_edge, wave_run};
      REG_LEVEL:  prdata[`DSO_DATA_W-1:0] = trig_level;
      REG_SHIFT:  prdata[`DSO_SHIFT_W-1:0] = h_shift;
      REG_DECI:   prdata[`DSO_DECI_W-1:0] = deci_ratio;
      REG_STATUS: begin
        prdata[1:0]  = capture_phase;
        prdata[15:8] = frame_cnt;
      end
      default: ;
    endcase
  end

endmodule

// File: dso_config.svh
`ifndef DSO_CONFIG_SVH
`define DSO_CONFIG_SVH

// ********************
// capture geometry
// ********************
`define DSO_HORIZONTAL 640    // stored samples and screen columns, even, max 1023
`define DSO_DATA_W     8      // adc sample width
`define DSO_ADDR_W     10     // ram and column address
`define DSO_SHIFT_W    10     // msb set means shift right
`define DSO_DECI_W     8      // decimation ratio

// ********************
// apb register offsets
// ********************
`define DSO_REG_CTRL   8'h00
`define DSO_REG_LEVEL  8'h04
`define DSO_REG_SHIFT  8'h08
`define DSO_REG_DECI   8'h0C
`define DSO_REG_STATUS 8'h10

`endif

// File: dso_pkg.sv
package dso_pkg;

  // apb register selector
  typedef enum logic [2:0] {
    REG_CTRL,
    REG_LEVEL,
    REG_SHIFT,
    REG_DECI,
    REG_STATUS,
    REG_NONE
  } dso_reg_e;

  // capture progress, read back in status bits 1:0
  typedef enum logic [1:0] {
    PRE_FILL  = 2'd0,
    ARMED     = 2'd1,
    POST_FILL = 2'd2,
    FULL      = 2'd3
  } capture_phase_e;

  typedef enum logic [1:0] {
    SW_IDLE,
    SW_RUN,
    SW_DONE
  } sweep_state_e;

endpackage

// File: dso_ram_2port.sv
`include "dso_config.svh"

module dso_ram_2port (
  input  logic                   ad_clk,
  input  logic                   wr_en,
  input  logic [`DSO_ADDR_W-1:0] wr_addr,
  input  logic [`DSO_DATA_W-1:0] wr_data,
  input  logic [`DSO_ADDR_W-1:0] rd_addr,
  output logic [`DSO_DATA_W-1:0] rd_data
);

  logic [`DSO_DATA_W-1:0] mem [0:`DSO_HORIZONTAL-1];   // one screen of samples

  always_ff @(posedge ad_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // one cycle read latency
  always_ff @(posedge ad_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: dso_top.sv
`include "dso_config.svh"

module dso_top (
  input  logic                   ad_clk,
  input  logic                   rstn,
  input  logic [`DSO_DATA_W-1:0] ad_data,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [7:0]             paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [`DSO_DATA_W-1:0] pix_data,
  output logic [`DSO_ADDR_W-1:0] pix_x,
  output logic                   pix_valid,
  output logic                   pix_last,
  input  logic                   pix_ready
);
  import dso_pkg::*;

  logic [`DSO_DATA_W-1:0]  sample_data;
  logic                    deci_valid;
  logic                    wave_run;
  logic                    trig_edge;
  logic [`DSO_DATA_W-1:0]  trig_level;
  logic [`DSO_SHIFT_W-1:0] h_shift;
  logic [`DSO_DECI_W-1:0]  deci_ratio;
  logic [`DSO_ADDR_W-1:0]  col_addr;
  logic [`DSO_DATA_W-1:0]  col_data;
  logic                    frame_ready;
  logic                    sweep_done;
  capture_phase_e          capture_phase;

  dso_apb_regs u_dso_apb_regs (
    .ad_clk        (ad_clk),
    .rstn          (rstn),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .capture_phase (capture_phase),
    .frame_done    (sweep_done),       // one count per sweep
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .wave_run      (wave_run),
    .trig_edge     (trig_edge),
    .trig_level    (trig_level),
    .h_shift       (h_shift),
    .deci_ratio    (deci_ratio)
  );

  sample_decimator u_sample_decimator (
    .ad_clk      (ad_clk),
    .rstn        (rstn),
    .ad_data     (ad_data),
    .deci_ratio  (deci_ratio),
    .sample_data (sample_data),
    .deci_valid  (deci_valid)
  );

  data_store u_data_store (
    .ad_clk        (ad_clk),
    .rstn          (rstn),
    .sample_data   (sample_data),
    .deci_valid    (deci_valid),
    .wave_run      (wave_run),
    .trig_edge     (trig_edge),
    .trig_level    (trig_level),
    .h_shift       (h_shift),
    .sweep_done    (sweep_done),
    .col_addr      (col_addr),
    .col_data      (col_data),
    .frame_ready   (frame_ready),
    .capture_phase (capture_phase)
  );

  wave_reader u_wave_reader (
    .ad_clk      (ad_clk),
    .rstn        (rstn),
    .frame_ready (frame_ready),
    .col_data    (col_data),
    .pix_ready   (pix_ready),
    .col_addr    (col_addr),
    .sweep_done  (sweep_done),
    .pix_data    (pix_data),
    .pix_x       (pix_x),
    .pix_valid   (pix_valid),
    .pix_last    (pix_last)
  );

endmodule

// File: filelist.f
+incdir+.
dso_pkg.sv
dso_ram_2port.sv
dso_apb_regs.sv
sample_decimator.sv
data_store.sv
wave_reader.sv
dso_top.sv
tb_dso.sv

// File: run_sim.sh
#!/bin/sh
# build and run the dso testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dso -f filelist.f -Mdir obj_dir -o sim_dso
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_dso > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "RESULT: FAIL (simulator exit status $run_status)"
  exit 1
fi
echo "RESULT: PASS"
exit 0

// File: sample_decimator.sv
`include "dso_config.svh"

module sample_decimator (
  input  logic                    ad_clk,
  input  logic                    rstn,
  input  logic [`DSO_DATA_W-1:0]  ad_data,
  input  logic [`DSO_DECI_W-1:0]  deci_ratio,
  output logic [`DSO_DATA_W-1:0]  sample_data,
  output logic                    deci_valid
);

  logic [`DSO_DECI_W-1:0] skip_cnt;    // idle cycles left before next strobe

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      skip_cnt   <= '0;
      deci_valid <= 1'b0;
    end else if (skip_cnt == '0) begin
      skip_cnt   <= deci_ratio;        // new ratio picked up here only
      deci_valid <= 1'b1;
    end else begin
      skip_cnt   <= skip_cnt - 1'b1;
      deci_valid <= 1'b0;
    end
  end

  // sample taken on the same edge that raises the strobe
  always_ff @(posedge ad_clk) begin
    if (skip_cnt == '0) begin
      sample_data <= ad_data;
    end
  end

endmodule

// File: tb_dso.sv
`include "dso_config.svh"

module tb_dso;
  timeunit 1ns;
  timeprecision 100ps;
  import dso_pkg::*;

  localparam int H           = `DSO_HORIZONTAL;
  localparam int HALF        = H / 2;
  localparam int CLK_PERIOD  = 100;
  localparam int NUM_CASES   = 5;
  localparam int MAX_RATIO   = 2;
  localparam int EDGE_SKIP   = 8;                    // record edge columns not compared
  localparam int CYCLE_LIMIT = NUM_CASES * (2 * H * (MAX_RATIO + 1) + 4 * H) + 2000;

  typedef struct packed {
    logic [7:0] level;
    logic       rising;
    logic [9:0] shift;                               // msb set means shift right
    logic [7:0] ratio;
  } case_t;

  logic        ad_clk = 1'b0;
  logic        rstn;
  logic [7:0]  ad_data;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [7:0]  pix_data;
  logic [9:0]  pix_x;
  logic        pix_valid;
  logic        pix_last;
  logic        pix_ready;

  case_t       cases [0:NUM_CASES-1];
  logic [31:0] lfsr_state = 32'hb442_33c4;
  int          cycle_cnt = 0;
  int unsigned in_cycle = 0;

  // capture model state
  int             skip_left;
  logic [7:0]     m_ratio;
  logic           m_run;
  logic           m_rising;
  logic [7:0]     m_level;
  logic           pend_valid;                        // strobe made at the last edge
  logic [7:0]     pend_data;
  logic [7:0]     hist_new;
  logic [7:0]     hist_mid;
  logic [7:0]     hist_old;
  capture_phase_e m_phase;
  int             m_written;
  int             m_post;
  int             m_xfers;
  int             m_full_age;                        // edges seen in full
  logic           done_pend;
  logic [7:0]     strobe_q [$];                      // every strobed sample
  int             trig_idx;

  dso_top UUT (
    .ad_clk    (ad_clk),
    .rstn      (rstn),
    .ad_data   (ad_data),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .pix_data  (pix_data),
    .pix_x     (pix_x),
    .pix_valid (pix_valid),
    .pix_last  (pix_last),
    .pix_ready (pix_ready)
  );

  always #(CLK_PERIOD / 2) ad_clk = ~ad_clk;

  // ********************
  // helpers
  // ********************
  function automatic logic [7:0] triangle(input int unsigned n);
    int unsigned p;
    p = n % 168;                                     // 0 up to 252 and back, step 3
    if (p <= 84) return 8'(3 * p);
    return 8'(3 * (168 - p));
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic draw_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
               $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge ad_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge ad_clk);
    penable = 1'b1;                                  // access phase
    #(CLK_PERIOD / 4);
    err = pslverr;
    check_value(32'(pready), 32'd1, "pready low in access phase");
    @(negedge ad_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge ad_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge ad_clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    data = prdata;
    err  = pslverr;
    @(negedge ad_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // ********************
  // stimulus and model
  // ********************
  initial begin
    ad_data = 8'd0;
    forever begin
      @(negedge ad_clk);
      ad_data = triangle(in_cycle);
      in_cycle++;
    end
  end

  // decimation, trigger search and sweep end, seen edge by edge
  always @(posedge ad_clk or negedge rstn) begin
    logic sweep_end;
    logic hit;
    if (!rstn) begin
      skip_left  = 0;
      m_ratio    = 8'd0;
      m_run      = 1'b0;
      m_rising   = 1'b1;
      m_level    = 8'd128;
      pend_valid = 1'b0;
      pend_data  = 8'd0;
      hist_new   = 8'd0;
      hist_mid   = 8'd0;
      hist_old   = 8'd0;
      m_phase    = PRE_FILL;
      m_written  = 0;
      m_post     = 0;
      m_xfers    = 0;
      m_full_age = 0;
      done_pend  = 1'b0;
      trig_idx   = 0;
    end else begin
      sweep_end = done_pend;                         // sweep_done seen at this edge
      done_pend = 1'b0;
      if (pix_valid && pix_ready) begin
        if (m_xfers == H - 1) begin
          m_xfers   = 0;
          done_pend = 1'b1;
        end else begin
          m_xfers++;
        end
      end
      if (pend_valid) begin
        hit = m_rising ?
          (hist_old < m_level && hist_mid < m_level && hist_new >= m_level && pend_data > m_level) :
          (hist_old > m_level && hist_mid > m_level && hist_new <= m_level && pend_data < m_level);
        strobe_q.push_back(pend_data);
        if (m_run) begin
          case (m_phase)
            PRE_FILL: begin
              m_written++;
              if (m_written == HALF) m_phase = ARMED;
            end
            ARMED: if (hit) begin
              m_phase  = POST_FILL;
              trig_idx = strobe_q.size() - 1;        // completing sample
              m_post   = 0;
            end
            POST_FILL: begin
              m_post++;
              if (m_post == HALF) m_phase = FULL;
            end
            default: ;
          endcase
        end
        hist_old = hist_mid;
        hist_mid = hist_new;
        hist_new = pend_data;
      end
      if (m_phase == FULL && sweep_end && m_run) begin
        m_phase   = PRE_FILL;
        m_written = 0;
      end
      if (m_phase == FULL) begin
        m_full_age++;
      end else begin
        m_full_age = 0;
      end
      if (skip_left == 0) begin
        pend_valid = 1'b1;
        pend_data  = ad_data;
        skip_left  = m_ratio;
      end else begin
        pend_valid = 1'b0;
        skip_left--;
      end
      if (psel && penable && pwrite) begin
        case (paddr)
          `DSO_REG_CTRL: begin
            m_run    = pwdata[0];
            m_rising = pwdata[1];
          end
          `DSO_REG_LEVEL: m_level = pwdata[7:0];
          `DSO_REG_DECI:  m_ratio = pwdata[7:0];
          default: ;
        endcase
      end
    end
  end

  always @(posedge ad_clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("TIMEOUT: the pixel stream did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  // ********************
  // checks
  // ********************
  task automatic check_pixel(input case_t tc, input int row, input int col);
    int cs;
    int idx;
    cs = tc.shift[9] ? col - int'(tc.shift[8:0]) : col + int'(tc.shift[8:0]);
    if (cs < 0 || cs > H - 1) begin
      check_value(32'(pix_data), 32'd255, $sformatf("row %0d col %0d off screen", row, col));
    end else if (cs >= EDGE_SKIP && cs <= H - 1 - EDGE_SKIP) begin
      idx = trig_idx + cs - (HALF - 2);
      check_value(32'(pix_data), 32'(strobe_q[idx]),
                  $sformatf("row %0d col %0d sample", row, col));
    end
  endtask

  task automatic collect_sweep(input case_t tc, input int row);
    int         col;
    logic       stalled;
    logic       ready_bit;
    logic [7:0] held_data;
    logic [9:0] held_x;
    col     = 0;
    stalled = 1'b0;
    while (col < H) begin
      @(negedge ad_clk);
      if (stalled) begin
        check_value(32'(pix_valid), 32'd1, "pix_valid dropped while stalled");
        check_value(32'(pix_data), 32'(held_data), "pix_data changed while stalled");
        check_value(32'(pix_x), 32'(held_x), "pix_x changed while stalled");
      end
      if (pix_valid) begin
        if (col == 0 && !stalled) begin
          // full at edge n, column 0 issued at n+1, pixel out at n+2
          check_value(32'(m_full_age), 32'd3, "first pixel latency after frame full");
        end
        check_value(32'(pix_x), 32'(col), "pix_x sequence");
        check_value(32'(pix_last), 32'(col == H - 1), "pix_last position");
      end else begin
        check_value(32'(pix_last), 32'd0, "pix_last without pix_valid");
      end
      draw_bit(ready_bit);
      pix_ready = ready_bit;
      stalled   = pix_valid && !ready_bit;
      held_data = pix_data;
      held_x    = pix_x;
      if (pix_valid && ready_bit) begin
        check_pixel(tc, row, col);
        col++;
      end
    end
  endtask

  task automatic check_registers();
    logic [7:0]  reg_addr [0:3];
    logic [31:0] reg_val  [0:3];
    logic [31:0] rd;
    logic        err;
    reg_addr = '{`DSO_REG_LEVEL, `DSO_REG_SHIFT, `DSO_REG_DECI, `DSO_REG_CTRL};
    reg_val  = '{32'h0000_005a, 32'h0000_02ab, 32'h0000_0007, 32'h0000_0002};
    for (int i = 0; i < 4; i++) begin
      apb_write(reg_addr[i], reg_val[i], err);
      check_value(32'(err), 32'd0, "pslverr on valid write");
    end
    apb_write(8'h14, 32'hffff_ffff, err);            // unmapped offset
    check_value(32'(err), 32'd1, "no pslverr on unknown write");
    apb_write(`DSO_REG_STATUS, 32'hffff_ffff, err);
    check_value(32'(err), 32'd1, "no pslverr on status write");
    apb_read(8'h20, rd, err);
    check_value(32'(err), 32'd1, "no pslverr on unknown read");
    for (int i = 0; i < 4; i++) begin
      apb_read(reg_addr[i], rd, err);
      check_value(32'(err), 32'd0, "pslverr on valid read");
      check_value(rd, reg_val[i], $sformatf("readback at 0x%0h", reg_addr[i]));
    end
    apb_read(`DSO_REG_STATUS, rd, err);
    check_value(rd, 32'd0, "status after reset");    // pre fill, no frames
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    rstn      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 8'd0;
    pwdata    = 32'd0;
    pix_ready = 1'b0;
    cases[0] = '{level: 8'd100, rising: 1'b1, shift: 10'd0, ratio: 8'd0};
    cases[1] = '{level: 8'd150, rising: 1'b0, shift: 10'd0, ratio: 8'd0};
    cases[2] = '{level: 8'd80,  rising: 1'b1, shift: {1'b0, 9'd100}, ratio: 8'd0};
    cases[3] = '{level: 8'd200, rising: 1'b0, shift: {1'b1, 9'd100}, ratio: 8'd0};
    cases[4] = '{level: 8'd120, rising: 1'b1, shift: 10'd0, ratio: 8'd2};
    repeat (3) @(posedge ad_clk);
    @(negedge ad_clk);
    rstn = 1'b1;
    check_registers();
    for (int row = 0; row < NUM_CASES; row++) begin
      apb_write(`DSO_REG_LEVEL, 32'(cases[row].level), err);
      check_value(32'(err), 32'd0, "pslverr on level write");
      apb_write(`DSO_REG_SHIFT, 32'(cases[row].shift), err);
      check_value(32'(err), 32'd0, "pslverr on shift write");
      apb_write(`DSO_REG_DECI, 32'(cases[row].ratio), err);
      check_value(32'(err), 32'd0, "pslverr on deci write");
      apb_write(`DSO_REG_CTRL, {30'd0, cases[row].rising, 1'b1}, err);
      check_value(32'(err), 32'd0, "pslverr on ctrl write");
      collect_sweep(cases[row], row);
      apb_read(`DSO_REG_STATUS, rd, err);
      check_value(32'(rd[15:8]), 32'((row + 1) % 256), "frame counter after sweep");
      check_value(32'(rd[1:0]), 32'(PRE_FILL), "capture not re-armed");
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: wave_reader.sv
`include "dso_config.svh"

module wave_reader (
  input  logic                   ad_clk,
  input  logic                   rstn,
  input  logic                   frame_ready,
  input  logic [`DSO_DATA_W-1:0] col_data,
  input  logic                   pix_ready,
  output logic [`DSO_ADDR_W-1:0] col_addr,
  output logic                   sweep_done,
  output logic [`DSO_DATA_W-1:0] pix_data,
  output logic [`DSO_ADDR_W-1:0] pix_x,
  output logic                   pix_valid,
  output logic                   pix_last
);
  import dso_pkg::*;

  localparam logic [`DSO_ADDR_W-1:0] LAST_COL = `DSO_ADDR_W'(`DSO_HORIZONTAL - 1);

  sweep_state_e state;
  logic         rd_pend;     // column address issued last cycle

  always_ff @(posedge ad_clk or negedge rstn) begin
    if (!rstn) begin
      state      <= SW_IDLE;
      col_addr   <= '0;
      rd_pend    <= 1'b0;
      pix_valid  <= 1'b0;
      pix_x      <= '0;
      sweep_done <= 1'b0;
    end else begin
      sweep_done <= 1'b0;
      rd_pend    <= 1'b0;
      case (state)
        SW_IDLE: if (frame_ready) begin
          state    <= SW_RUN;
          col_addr <= '0;
          rd_pend  <= 1'b1;                          // column 0 goes out
        end
        SW_RUN: begin
          if (rd_pend) begin
            pix_valid <= 1'b1;
            pix_x     <= col_addr;
          end else if (pix_valid && pix_ready) begin
            pix_valid <= 1'b0;
            if (pix_x == LAST_COL) begin
              state      <= SW_DONE;
              sweep_done <= 1'b1;
            end else begin
              col_addr <= col_addr + 1'b1;           // next column on transfer
              rd_pend  <= 1'b1;
            end
          end
        end
        SW_DONE: if (!frame_ready) state <= SW_IDLE;  // wait for capture restart
        default: state <= SW_IDLE;
      endcase
    end
  end

  // col_addr holds during a stall, so the ram output holds too
  assign pix_data = col_data;
  assign pix_last = pix_valid && (pix_x == LAST_COL);

endmodule
